// ==== design/bankReadIf.sv ====
`timescale 1ns/1ps

// One read request into a line bank and the line it returns a cycle later.
interface bankReadIf #(
    parameter int AddrWidth = 10
);
    localparam int BankIdxWidth = AddrWidth - 5;

    logic readEn;                      // Sampled by the bank on the clock edge.
    logic [BankIdxWidth-1:0] lineIndex; // Line within the bank without its parity bit.
    loadAlignPkg::lineData_t lineData; // Held until the next read.

    modport requester (
        output readEn,
        output lineIndex,
        input  lineData
    );

    modport bank (
        input  readEn,
        input  lineIndex,
        output lineData
    );

endinterface

// ==== design/lineBank.sv ====
`timescale 1ns/1ps

module lineBank #(
    parameter int AddrWidth = 10,
    localparam int BankIdxWidth = AddrWidth - 5
) (
    input  logic clk,
    input  logic reset,
    input  logic wrEn,
    input  logic [BankIdxWidth-1:0] wrIndex,
    input  loadAlignPkg::lineData_t wrData,
    bankReadIf.bank rd
);

    localparam int BankLines = 1 << BankIdxWidth;

    loadAlignPkg::lineData_t lines [BankLines];

    // Line fills from the write port.
    always_ff @(posedge clk) begin
        if (wrEn) begin
            lines[wrIndex] <= wrData;
        end
    end

    // The read register keeps the last line until another read is issued.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd.lineData <= '0;
        end else if (rd.readEn) begin
            rd.lineData <= lines[rd.lineIndex]; // Same-cycle fill is not visible yet.
        end
    end

endmodule

// ==== design/loadAlignPkg.sv ====
package loadAlignPkg;

    //////////////////////////////////////////////////
    // Line and result geometry
    //////////////////////////////////////////////////

    localparam int LineBytes = 16; // Bytes per cache line.
    localparam int LoadBytes = 8;  // Widest load result in bytes.

    typedef logic [LineBytes*8-1:0] lineData_t;
    typedef logic [LoadBytes*8-1:0] loadData_t;
    typedef logic [LoadBytes-1:0] byteMask_t;
    typedef logic [$clog2(LineBytes)-1:0] lineOffset_t;

    //////////////////////////////////////////////////
    // Access size encoding
    //////////////////////////////////////////////////

    typedef logic [1:0] loadSize_t;

    localparam loadSize_t SizeByte = 2'd0;   // 1 byte.
    localparam loadSize_t SizeHalf = 2'd1;   // 2 bytes.
    localparam loadSize_t SizeWord = 2'd2;   // 4 bytes.
    localparam loadSize_t SizeDouble = 2'd3; // 8 bytes.

    // Number of bytes covered by an access of the given size.
    function automatic logic [4:0] sizeToBytes(input loadSize_t sizeCode);
        return 5'd1 << sizeCode;
    endfunction

endpackage

// ==== design/loadPipe.sv ====
`timescale 1ns/1ps

module loadPipe #(
    parameter int AddrWidth = 10,
    parameter int ReqCredits = 4,
    parameter int RespCredits = 2,
    localparam int LineIdxWidth = AddrWidth - 4
) (
    input  logic clk,
    input  logic reset,
    input  logic reqValid,
    input  logic [AddrWidth-1:0] reqAddr,
    input  loadAlignPkg::loadSize_t reqSize,
    output logic reqCreditReturn,
    input  logic respCreditReturn,
    input  logic wrEn,
    input  logic [LineIdxWidth-1:0] wrIndex,
    input  loadAlignPkg::lineData_t wrData,
    output logic respValid,
    output loadAlignPkg::loadData_t respData,
    output loadAlignPkg::byteMask_t respMask
);

    logic issueValid;
    loadAlignPkg::lineOffset_t offset;
    loadAlignPkg::loadSize_t size;
    logic needNext;
    logic oddLower;

    bankReadIf #(.AddrWidth(AddrWidth)) evenRead ();
    bankReadIf #(.AddrWidth(AddrWidth)) oddRead ();

    loadRequest #(
        .AddrWidth  (AddrWidth),
        .ReqCredits (ReqCredits),
        .RespCredits(RespCredits)
    ) request_i (
        .clk             (clk),
        .reset           (reset),
        .reqValid        (reqValid),
        .reqAddr         (reqAddr),
        .reqSize         (reqSize),
        .reqCreditReturn (reqCreditReturn),
        .respCreditReturn(respCreditReturn),
        .evenRd          (evenRead),
        .oddRd           (oddRead),
        .issueValid      (issueValid),
        .offset          (offset),
        .size            (size),
        .needNext        (needNext),
        .oddLower        (oddLower)
    );

    // The parity bit of the fill index picks the bank.
    lineBank #(.AddrWidth(AddrWidth)) evenBank_i (
        .clk    (clk),
        .reset  (reset),
        .wrEn   (wrEn && !wrIndex[0]),
        .wrIndex(wrIndex[LineIdxWidth-1:1]),
        .wrData (wrData),
        .rd     (evenRead)
    );

    lineBank #(.AddrWidth(AddrWidth)) oddBank_i (
        .clk    (clk),
        .reset  (reset),
        .wrEn   (wrEn && wrIndex[0]),
        .wrIndex(wrIndex[LineIdxWidth-1:1]),
        .wrData (wrData),
        .rd     (oddRead)
    );

    outputAlign align_i (
        .clk       (clk),
        .reset     (reset),
        .issueValid(issueValid),
        .offset    (offset),
        .size      (size),
        .needNext  (needNext),
        .oddLower  (oddLower),
        .evenLine  (evenRead.lineData),
        .oddLine   (oddRead.lineData),
        .respValid (respValid),
        .respData  (respData),
        .respMask  (respMask)
    );

endmodule

// ==== design/loadRequest.sv ====
`timescale 1ns/1ps

module loadRequest #(
    parameter int AddrWidth = 10,
    parameter int ReqCredits = 4,
    parameter int RespCredits = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic reqValid,
    input  logic [AddrWidth-1:0] reqAddr,
    input  loadAlignPkg::loadSize_t reqSize,
    output logic reqCreditReturn,
    input  logic respCreditReturn,
    bankReadIf.requester evenRd,
    bankReadIf.requester oddRd,
    output logic issueValid,
    output loadAlignPkg::lineOffset_t offset,
    output loadAlignPkg::loadSize_t size,
    output logic needNext,
    output logic oddLower
);

    localparam int LineIdxWidth = AddrWidth - 4;
    localparam int BankIdxWidth = AddrWidth - 5;
    localparam int PtrWidth = (ReqCredits > 1) ? $clog2(ReqCredits) : 1;
    localparam int FillWidth = $clog2(ReqCredits + 1);
    localparam int CreditWidth = $clog2(RespCredits + 1);

    logic [AddrWidth-1:0] fifoAddr [ReqCredits];
    loadAlignPkg::loadSize_t fifoSize [ReqCredits];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [FillWidth-1:0] fillCount;
    logic [CreditWidth-1:0] respCount;
    logic issueNow;

    logic [AddrWidth-1:0] headAddr;
    loadAlignPkg::loadSize_t headSize;
    loadAlignPkg::lineOffset_t headOffset;
    logic [LineIdxWidth-1:0] lineIdx;
    logic [LineIdxWidth-1:0] nextIdx;
    logic [BankIdxWidth-1:0] evenIdx;
    logic [BankIdxWidth-1:0] oddIdx;
    logic headNeedNext;

    logic stageValid;
    loadAlignPkg::lineOffset_t stageOffset;
    loadAlignPkg::loadSize_t stageSize;
    logic stageNeedNext;
    logic stageOddLower;

    function automatic logic [PtrWidth-1:0] advance(input logic [PtrWidth-1:0] ptr);
        if (ptr == PtrWidth'(ReqCredits - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Request FIFO and credit counters
    //////////////////////////////////////////////////

    // The sender holds one credit per free entry, so a push always has room.
    always_ff @(posedge clk) begin
        if (reqValid) begin
            fifoAddr[wrPtr] <= reqAddr;
            fifoSize[wrPtr] <= reqSize;
        end
    end

    assign issueNow = (fillCount != '0) && (respCount != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fillCount <= '0;
            respCount <= CreditWidth'(RespCredits);
        end else begin
            if (reqValid) wrPtr <= advance(wrPtr);
            if (issueNow) rdPtr <= advance(rdPtr);
            case ({reqValid, issueNow})
                2'b10: fillCount <= fillCount + 1'b1;
                2'b01: fillCount <= fillCount - 1'b1;
                default: ;
            endcase
            case ({issueNow, respCreditReturn})
                2'b10: respCount <= respCount - 1'b1;
                2'b01: respCount <= respCount + 1'b1;
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Address split and bank issue
    //////////////////////////////////////////////////

    assign headAddr = fifoAddr[rdPtr];
    assign headSize = fifoSize[rdPtr];
    assign headOffset = headAddr[3:0];
    assign lineIdx = headAddr[AddrWidth-1:4];
    assign nextIdx = lineIdx + 1'b1; // The last line wraps to line zero.
    assign headNeedNext = ({1'b0, headOffset} + loadAlignPkg::sizeToBytes(headSize))
                          > 5'(loadAlignPkg::LineBytes);

    // The odd line above an even lower line shares its bank index.
    assign oddIdx = lineIdx[LineIdxWidth-1:1];
    assign evenIdx = lineIdx[0] ? nextIdx[LineIdxWidth-1:1] : lineIdx[LineIdxWidth-1:1];

    always_ff @(posedge clk) begin
        if (reset) begin
            evenRd.readEn <= 1'b0;
            oddRd.readEn <= 1'b0;
            stageValid <= 1'b0;
            issueValid <= 1'b0;
            reqCreditReturn <= 1'b0;
        end else begin
            evenRd.readEn <= issueNow && (!lineIdx[0] || headNeedNext);
            oddRd.readEn <= issueNow && (lineIdx[0] || headNeedNext);
            stageValid <= issueNow;
            issueValid <= stageValid; // Lines up with the bank read register.
            reqCreditReturn <= issueNow;
        end
    end

    always_ff @(posedge clk) begin
        if (issueNow) begin
            evenRd.lineIndex <= evenIdx;
            oddRd.lineIndex <= oddIdx;
            stageOffset <= headOffset;
            stageSize <= headSize;
            stageNeedNext <= headNeedNext;
            stageOddLower <= lineIdx[0];
        end
        offset <= stageOffset;
        size <= stageSize;
        needNext <= stageNeedNext;
        oddLower <= stageOddLower;
    end

endmodule

// ==== design/outputAlign.sv ====
`timescale 1ns/1ps

module outputAlign (
    input  logic clk,
    input  logic reset,
    input  logic issueValid,
    input  loadAlignPkg::lineOffset_t offset,
    input  loadAlignPkg::loadSize_t size,
    input  logic needNext,
    input  logic oddLower,
    input  loadAlignPkg::lineData_t evenLine,
    input  loadAlignPkg::lineData_t oddLine,
    output logic respValid,
    output loadAlignPkg::loadData_t respData,
    output loadAlignPkg::byteMask_t respMask
);

    localparam int LoadBytes = loadAlignPkg::LoadBytes;
    localparam int LineBits = loadAlignPkg::LineBytes * 8;

    loadAlignPkg::lineData_t lowerLine;
    loadAlignPkg::lineData_t upperLine;
    loadAlignPkg::lineData_t rotated;
    logic [2*LineBits-1:0] doubled;
    logic [4:0] bytePos [LoadBytes];
    loadAlignPkg::loadData_t merged;
    loadAlignPkg::loadData_t extended;
    loadAlignPkg::byteMask_t mask;

    //////////////////////////////////////////////////
    // Bank ordering and rotation
    //////////////////////////////////////////////////

    assign lowerLine = oddLower ? oddLine : evenLine;
    assign upperLine = oddLower ? evenLine : oddLine;

    // Shifting two copies of the line gives a right rotation in the low half.
    assign doubled = {lowerLine, lowerLine} >> {offset, 3'b000};
    assign rotated = doubled[LineBits-1:0];

    // A result byte whose line position carries past 15 belongs to the upper line.
    always_comb begin
        for (int k = 0; k < LoadBytes; k++) begin
            bytePos[k] = {1'b0, offset} + 5'(k);
            if (needNext && bytePos[k][4]) begin
                merged[k*8 +: 8] = upperLine[{bytePos[k][3:0], 3'b000} +: 8];
            end else begin
                merged[k*8 +: 8] = rotated[k*8 +: 8];
            end
        end
    end

    //////////////////////////////////////////////////
    // Sign extension and byte mask
    //////////////////////////////////////////////////

    always_comb begin
        unique case (size)
            loadAlignPkg::SizeByte: begin
                extended = {{56{merged[7]}}, merged[7:0]};
                mask = 8'h01;
            end
            loadAlignPkg::SizeHalf: begin
                extended = {{48{merged[15]}}, merged[15:0]};
                mask = 8'h03;
            end
            loadAlignPkg::SizeWord: begin
                extended = {{32{merged[31]}}, merged[31:0]};
                mask = 8'h0F;
            end
            loadAlignPkg::SizeDouble: begin
                extended = merged;
                mask = 8'hFF;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            respValid <= 1'b0;
        end else begin
            respValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            respData <= extended;
            respMask <= mask;
        end
    end

endmodule

// ==== loadPipe.f ====
design/loadAlignPkg.sv
design/bankReadIf.sv
design/lineBank.sv
design/loadRequest.sv
design/outputAlign.sv
design/loadPipe.sv
sim/loadPipe_asserts.sv
sim/loadPipeTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the loadPipe testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module loadPipeTb -f loadPipe.f -o simv
if [ $? -ne 0 ]; then
    echo "Compile step failed"
    exit 1
fi

./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
    exit 0
else
    exit 1
fi

// ==== sim/loadPipeTb.sv ====
`timescale 1ns/1ps

module loadPipeTb;

    localparam int AddrWidth = 10;
    localparam int ReqCredits = 4;
    localparam int RespCredits = 2;
    localparam int LineIdxWidth = AddrWidth - 4;
    localparam int WaitLimit = 300;

    logic clk;
    logic reset;
    logic reqValid;
    logic [AddrWidth-1:0] reqAddr;
    loadAlignPkg::loadSize_t reqSize;
    logic reqCreditReturn;
    logic respCreditReturn;
    logic wrEn;
    logic [LineIdxWidth-1:0] wrIndex;
    loadAlignPkg::lineData_t wrData;
    logic respValid;
    loadAlignPkg::loadData_t respData;
    loadAlignPkg::byteMask_t respMask;

    int reqCredits;
    int sentCount;
    int creditPulses;
    int respCount;
    int owedCredits;
    int timeouts;
    int checkFails;
    int testsFailed;
    int testNum;
    int startFails;
    bit holdCredits;
    int unsigned seed;
    loadAlignPkg::lineData_t line;

    loadPipe dut_i (.*);

    bind loadPipe loadPipeAsserts #(
        .AddrWidth(AddrWidth), .ReqCredits(ReqCredits), .RespCredits(RespCredits)
    ) asserts_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!reset) begin
            if (reqCreditReturn) begin
                reqCredits++;
                creditPulses++;
            end
            if (respValid) begin
                respCount++;
                owedCredits++;
            end
        end
    end

    // Response credits go back on a random schedule unless held.
    always @(negedge clk) begin
        if (!reset && !holdCredits && owedCredits > 0 && ($urandom % 3 != 0)) begin
            respCreditReturn = 1'b1;
            owedCredits--;
        end else begin
            respCreditReturn = 1'b0;
        end
    end

    function automatic int totalFails();
        return dut_i.asserts_i.failCount + timeouts + checkFails;
    endfunction

    task automatic startTest(input int num);
        testNum = num;
        startFails = totalFails();
    endtask

    task automatic endTest(input string name);
        if (totalFails() == startFails) begin
            $display("Test %0d (%s): ok", testNum, name);
        end else begin
            testsFailed++;
            $display("Test %0d (%s): %0d errors", testNum, name, totalFails() - startFails);
        end
    endtask

    task automatic fillLine(input int idx, input loadAlignPkg::lineData_t data);
        wrEn = 1'b1;
        wrIndex = LineIdxWidth'(idx);
        wrData = data;
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    task automatic sendLoad(input int addr, input int sz);
        int waited;
        waited = 0;
        while (reqCredits == 0 && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (reqCredits == 0) begin
            $display("Timeout: no upstream credit came back at %0t", $time);
            timeouts++;
        end else begin
            reqValid = 1'b1;
            reqAddr = AddrWidth'(addr);
            reqSize = 2'(sz);
            reqCredits--;
            sentCount++;
            @(negedge clk);
            reqValid = 1'b0;
        end
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while ((respCount != sentCount || creditPulses != sentCount) && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (respCount != sentCount || creditPulses != sentCount) begin
            $display("Timeout: responses or credits still missing at %0t", $time);
            timeouts++;
        end
    endtask

    initial begin
        int waited;
        seed = 49723;
        void'($urandom(seed));
        reset = 1'b1;
        {reqValid, reqAddr, reqSize, respCreditReturn, wrEn, wrIndex, wrData} = '0;
        {reqCredits, sentCount, creditPulses, respCount, owedCredits} = '0;
        {timeouts, checkFails, testsFailed} = '0;
        holdCredits = 1'b0;
        reqCredits = ReqCredits;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        startTest(1);
        for (int i = 0; i < (1 << LineIdxWidth); i++) begin
            for (int w = 0; w < 4; w++) line[w*32 +: 32] = $urandom;
            fillLine(i, line);
        end
        repeat (10) @(negedge clk);
        endTest("quiet after reset");

        startTest(2);
        sendLoad(12'h040, 3);
        sendLoad(12'h050, 3);
        waitDrain();
        endTest("aligned doubleword");

        startTest(3);
        for (int base = 12'h060; base <= 12'h070; base += 16) begin
            for (int sz = 0; sz < 4; sz++) begin
                for (int off = 0; off < 16; off++) begin
                    if (off + (1 << sz) > 16) sendLoad(base + off, sz);
                end
            end
        end
        sendLoad(12'h3FA, 3); // Last line wraps to line zero.
        waitDrain();
        endTest("line crossing");

        startTest(4);
        for (int b = 0; b < 16; b++) line[b*8 +: 8] = {b[0], 7'(b * 9)};
        fillLine(10, line);
        for (int sz = 0; sz < 3; sz++) begin
            for (int off = 0; off < 8; off++) sendLoad(12'h0A0 + off, sz);
        end
        waitDrain();
        endTest("sign extension");

        startTest(5);
        holdCredits = 1'b1;
        for (int i = 0; i < 4; i++) sendLoad(12'h100 + i * 13, i % 4);
        waited = 0;
        while (owedCredits < RespCredits && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (owedCredits < RespCredits) begin
            $display("Timeout: responses did not use up the credits");
            timeouts++;
        end
        repeat (20) @(negedge clk);
        holdCredits = 1'b0;
        waitDrain();
        endTest("withheld credits");

        startTest(6);
        for (int i = 0; i < 16; i++) sendLoad($urandom % 1024, $urandom % 4);
        waitDrain();
        if (creditPulses != sentCount) begin
            $display("FAILED at %0t: reqCreditReturn pulses got %0d expected %0d",
                     $time, creditPulses, sentCount);
            checkFails++;
        end
        if (reqCredits != ReqCredits) begin
            $display("FAILED at %0t: reqCredits got %0d expected %0d",
                     $time, reqCredits, ReqCredits);
            checkFails++;
        end
        endTest("burst credits");

        $display("Tests run 6, tests failed %0d, errors %0d", testsFailed, totalFails());
        if (totalFails() == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim/loadPipe_asserts.sv ====
`timescale 1ns/1ps

module loadPipeAsserts #(
    parameter int AddrWidth = 10,
    parameter int ReqCredits = 4,
    parameter int RespCredits = 2,
    localparam int LineIdxWidth = AddrWidth - 4
) (
    input logic clk,
    input logic reset,
    input logic reqValid,
    input logic [AddrWidth-1:0] reqAddr,
    input loadAlignPkg::loadSize_t reqSize,
    input logic reqCreditReturn,
    input logic respCreditReturn,
    input logic wrEn,
    input logic [LineIdxWidth-1:0] wrIndex,
    input loadAlignPkg::lineData_t wrData,
    input logic respValid,
    input loadAlignPkg::loadData_t respData,
    input loadAlignPkg::byteMask_t respMask
);

    loadAlignPkg::lineData_t shadow [1 << LineIdxWidth];
    logic [63:0] expData [$];
    logic [7:0] expMask [$];
    logic [63:0] headData;
    logic [7:0] headMask;
    int pendingCount;
    int heldResp;       // Responses delivered and not yet credited back.
    int upCredits;      // Credits the sender holds.
    bit anySent;
    int unsigned failCount;

    // Gathers the bytes at addr and up from the shadow lines, then sign-extends.
    function automatic logic [63:0] expectLoad(input logic [AddrWidth-1:0] addr,
                                               input logic [1:0] sz);
        logic [63:0] value;
        logic [AddrWidth-1:0] a;
        int n;
        value = '0;
        n = (sz == 2'd0) ? 1 : (sz == 2'd1) ? 2 : (sz == 2'd2) ? 4 : 8;
        for (int i = 0; i < 8; i++) begin
            a = addr + AddrWidth'(i);
            if (i < n) begin
                value[i*8 +: 8] = shadow[a[AddrWidth-1:4]][a[3:0]*8 +: 8];
            end else begin
                value[i*8 +: 8] = {8{value[n*8-1]}};
            end
        end
        return value;
    endfunction

    always @(posedge clk) begin
        if (wrEn) shadow[wrIndex] <= wrData;
        if (reset) begin
            expData.delete();
            expMask.delete();
            heldResp <= 0;
            upCredits <= ReqCredits;
            anySent <= 1'b0;
        end else begin
            if (respValid) begin
                void'(expData.pop_front());
                void'(expMask.pop_front());
            end
            if (reqValid) begin
                expData.push_back(expectLoad(reqAddr, reqSize));
                expMask.push_back(8'((16'd1 << (1 << reqSize)) - 1));
                anySent <= 1'b1;
            end
            heldResp <= heldResp + int'(respValid) - int'(respCreditReturn);
            upCredits <= upCredits - int'(reqValid) + int'(reqCreditReturn);
        end
    end

    always_comb begin
        pendingCount = expData.size();
        headData = (pendingCount != 0) ? expData[0] : '0;
        headMask = (pendingCount != 0) ? expMask[0] : '0;
    end

    //////////////////////////////////////////////////
    // Response checks
    //////////////////////////////////////////////////

    dataMatch: assert property (@(posedge clk) disable iff (reset)
        respValid |-> (respData == headData && respMask == headMask))
        else begin
            failCount++;
            $error("FAILED at %0t: respData got %h expected %h, respMask got %h expected %h",
                   $time, respData, headData, respMask, headMask);
        end

    noSpuriousResp: assert property (@(posedge clk) disable iff (reset)
        respValid |-> pendingCount != 0)
        else begin
            failCount++;
            $error("A response came with no request outstanding.");
        end

    respCreditLimit: assert property (@(posedge clk) disable iff (reset)
        respValid |-> heldResp < RespCredits)
        else begin
            failCount++;
            $error("A response came while no credit was free.");
        end

    quietBeforeRequest: assert property (@(posedge clk) disable iff (reset)
        !anySent |-> (!respValid && !reqCreditReturn))
        else begin
            failCount++;
            $error("Outputs moved before any request was sent.");
        end

    //////////////////////////////////////////////////
    // Upstream credit checks
    //////////////////////////////////////////////////

    creditReturnBound: assert property (@(posedge clk) disable iff (reset)
        reqCreditReturn |-> upCredits < ReqCredits)
        else begin
            failCount++;
            $error("More credits came back than were spent.");
        end

endmodule
